// File: rtl/opn_pkg.sv
package opn_pkg;

    // Vector types with a meaning on the host side
    typedef logic [7:0] reg_addr_t;   // Selected register number
    typedef logic [7:0] reg_data_t;   // Byte written by the host
    typedef logic [2:0] ch_sel_t;     // {part, addr[1:0]}
    typedef logic [1:0] op_sel_t;     // Operator slot
    typedef logic [9:0] timer_a_t;
    typedef logic [7:0] timer_b_t;
    typedef logic [8:0] pcm_t;        // DAC sample
    typedef logic [1:0] div_sel_t;    // Prescaler selection
    typedef logic [2:0] ch_upd_t;     // One-hot channel register strobes
    typedef logic [6:0] op_upd_t;     // One-hot operator register strobes

    // Global register map
    localparam reg_addr_t REG_TESTYM  = 8'h21;
    localparam reg_addr_t REG_LFO     = 8'h22;
    localparam reg_addr_t REG_CLKA1   = 8'h24;
    localparam reg_addr_t REG_CLKA2   = 8'h25;
    localparam reg_addr_t REG_CLKB    = 8'h26;
    localparam reg_addr_t REG_TIMER   = 8'h27;
    localparam reg_addr_t REG_KON     = 8'h28;
    localparam reg_addr_t REG_PCM     = 8'h2A;
    localparam reg_addr_t REG_PCM_EN  = 8'h2B;
    localparam reg_addr_t REG_DACTEST = 8'h2C;

    // Prescaler writes ignore the data byte
    localparam reg_addr_t REG_CLK_N6  = 8'h2D;
    localparam reg_addr_t REG_CLK_N3  = 8'h2E;
    localparam reg_addr_t REG_CLK_N2  = 8'h2F;

    // Busy length in synthesis clock enables
    localparam int BUSY_CYCLES = 32;

endpackage

// File: rtl/opn_bus_latch.sv
`timescale 1ns/1ps

module opn_bus_latch
    import opn_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_data_t din,
    input  logic      write,
    input  logic [1:0] addr,
    output logic      data_wr,
    output reg_addr_t sel_reg,
    output logic      part,
    output reg_data_t data
);

    logic write_q;   // Previous value of write
    logic write_rise;

    // Writes act once per host access
    assign write_rise = write & ~write_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            write_q <= 1'b0;
        end else begin
            write_q <= write;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg <= '0;
            part    <= 1'b0;
            data    <= '0;
            data_wr <= 1'b0;
        end else begin
            data_wr <= write_rise & addr[0];
            if (write_rise) begin
                if (!addr[0]) begin
                    sel_reg <= din;
                    part    <= addr[1];   // Upper register bank
                end else begin
                    data <= din;
                end
            end
        end
    end

endmodule

// File: rtl/opn_global_regs.sv
`timescale 1ns/1ps

module opn_global_regs
    import opn_pkg::*;
#(
    parameter int USE_PCM = 1
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       clk_en,
    input  logic       data_wr,
    input  reg_addr_t  sel_reg,
    input  reg_data_t  data,
    output div_sel_t   div_sel,
    output logic       eg_stop,
    output logic       pg_stop,
    output logic       fast_timers,
    output timer_a_t   value_a,
    output timer_b_t   value_b,
    output logic       load_a,
    output logic       load_b,
    output logic       enable_irq_a,
    output logic       enable_irq_b,
    output logic       clr_flag_a,
    output logic       clr_flag_b,
    output logic       csm,
    output logic       effect,
    output logic [2:0] lfo_freq,
    output logic       lfo_en,
    output pcm_t       pcm,
    output logic       pcm_en,
    output logic       pcm_wr
);

    always_ff @(posedge clk) begin
        if (rst) begin
            div_sel      <= 2'b11;   // Slowest clock out of reset
            eg_stop      <= 1'b0;
            pg_stop      <= 1'b0;
            fast_timers  <= 1'b0;
            value_a      <= '0;
            value_b      <= '0;
            {clr_flag_b, clr_flag_a, enable_irq_b, enable_irq_a, load_b, load_a} <= '0;
            csm          <= 1'b0;
            effect       <= 1'b0;
            lfo_freq     <= '0;
            lfo_en       <= 1'b0;
            pcm          <= '0;
            pcm_en       <= 1'b0;
            pcm_wr       <= 1'b0;
        end else begin
            pcm_wr <= 1'b0;   // Single-cycle pulse
            if (data_wr) begin
                case (sel_reg)
                    REG_TESTYM: begin
                        eg_stop     <= data[5];
                        pg_stop     <= data[3];
                        fast_timers <= data[2];
                    end
                    REG_CLKA1: value_a[9:2] <= data;
                    REG_CLKA2: value_a[1:0] <= data[1:0];
                    REG_CLKB:  value_b      <= data;
                    REG_TIMER: begin
                        effect <= |data[7:6];
                        csm    <= data[7:6] == 2'b10;
                        {clr_flag_b, clr_flag_a, enable_irq_b, enable_irq_a,
                         load_b, load_a} <= data[5:0];
                    end
                    REG_LFO:    {lfo_en, lfo_freq} <= data[3:0];
                    REG_CLK_N6: div_sel[1] <= 1'b1;
                    REG_CLK_N3: div_sel[0] <= 1'b1;
                    REG_CLK_N2: div_sel    <= 2'b00;
                    default: ;
                endcase
                if (USE_PCM != 0) begin
                    case (sel_reg)
                        REG_PCM: begin
                            // Offset binary to 9 bits with the LSB set
                            pcm    <= {~data[7], data[6:0], 1'b1};
                            pcm_wr <= 1'b1;
                        end
                        REG_DACTEST: pcm[0] <= data[3];
                        REG_PCM_EN:  pcm_en <= data[7];
                        default: ;
                    endcase
                end
            end else if (clk_en) begin
                clr_flag_a <= 1'b0;   // Seen by the timers for one clk_en
                clr_flag_b <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/opn_update_decode.sv
`timescale 1ns/1ps

module opn_update_decode
    import opn_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      data_wr,
    input  logic      part,
    input  reg_addr_t sel_reg,
    input  reg_data_t data,
    output reg_data_t reg_data,
    output logic      up_keyon,
    output ch_sel_t   up_ch,
    output op_sel_t   up_op,
    output ch_upd_t   up_chreg,
    output op_upd_t   up_opreg
);

    ch_upd_t ch_hit;
    op_upd_t op_hit;

    // Which operator bank register gets the byte
    always_comb begin
        ch_hit = '0;
        op_hit = '0;
        if (sel_reg[1:0] != 2'b11) begin   // Slot 3 of each group is unused
            casez (sel_reg)
                8'hA0, 8'hA1, 8'hA2: ch_hit = 3'b001;   // Fnum low
                8'hB0, 8'hB1, 8'hB2: ch_hit = 3'b010;   // FB and algorithm
                8'hB4, 8'hB5, 8'hB6: ch_hit = 3'b100;   // PMS/AMS
                8'h3?: op_hit = 7'h01;
                8'h4?: op_hit = 7'h02;
                8'h5?: op_hit = 7'h04;
                8'h6?: op_hit = 7'h08;
                8'h7?: op_hit = 7'h10;
                8'h8?: op_hit = 7'h20;
                8'h9?: op_hit = 7'h40;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_data <= '0;
            up_ch    <= '0;
            up_op    <= '0;
            up_keyon <= 1'b0;
            up_chreg <= '0;
            up_opreg <= '0;
        end else begin
            up_keyon <= data_wr && sel_reg == REG_KON;
            up_chreg <= data_wr ? ch_hit : '0;
            up_opreg <= data_wr ? op_hit : '0;
            if (data_wr) begin
                reg_data <= data;
                up_ch    <= {part, sel_reg[1:0]};
                up_op    <= sel_reg[3:2];   // 0=S1, 1=S3, 2=S2, 3=S4
            end
        end
    end

endmodule

// File: rtl/opn_prescaler.sv
`timescale 1ns/1ps

module opn_prescaler
    import opn_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cen,
    input  div_sel_t div_sel,
    output logic     clk_en
);

    logic [2:0] cnt;
    logic [2:0] cnt_max;
    div_sel_t   div_q;   // Selection the counter runs with

    always_comb begin
        case (div_sel)
            2'b00:   cnt_max = 3'd1;   // Divide by 2
            2'b01:   cnt_max = 3'd2;   // Divide by 3
            default: cnt_max = 3'd5;   // Divide by 6
        endcase
    end

    assign clk_en = cen & (cnt == cnt_max);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt   <= '0;
            div_q <= 2'b11;
        end else begin
            div_q <= div_sel;
            if (div_sel != div_q) begin
                cnt <= '0;   // New ratio starts a fresh period
            end else if (cen) begin
                cnt <= (cnt == cnt_max) ? 3'd0 : cnt + 3'd1;
            end
        end
    end

endmodule

// File: rtl/opn_busy_timer.sv
`timescale 1ns/1ps

module opn_busy_timer
    import opn_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic clk_en,
    input  logic data_wr,
    output logic busy
);

    localparam int CNT_W = $clog2(BUSY_CYCLES);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (data_wr) begin
            // Any data write restarts the count
            busy <= 1'b1;
            cnt  <= '0;
        end else if (clk_en && busy) begin
            if (cnt == CNT_W'(BUSY_CYCLES - 1)) begin
                busy <= 1'b0;
            end
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// File: rtl/opn_mmr.sv
`timescale 1ns/1ps

module opn_mmr
    import opn_pkg::*;
#(
    parameter int USE_PCM = 1
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  reg_data_t  din,
    input  logic       write,
    input  logic [1:0] addr,
    output logic       clk_en,
    output logic       busy,
    // Global registers
    output logic       eg_stop,
    output logic       pg_stop,
    output logic       fast_timers,
    output timer_a_t   value_a,
    output timer_b_t   value_b,
    output logic       load_a,
    output logic       load_b,
    output logic       enable_irq_a,
    output logic       enable_irq_b,
    output logic       clr_flag_a,
    output logic       clr_flag_b,
    output logic       csm,
    output logic       effect,
    output logic [2:0] lfo_freq,
    output logic       lfo_en,
    output pcm_t       pcm,
    output logic       pcm_en,
    output logic       pcm_wr,
    // Towards the operator register bank
    output reg_data_t  reg_data,
    output logic       up_keyon,
    output ch_sel_t    up_ch,
    output op_sel_t    up_op,
    output ch_upd_t    up_chreg,
    output op_upd_t    up_opreg
);

    logic      data_wr;
    reg_addr_t sel_reg;
    logic      part;
    reg_data_t data;
    div_sel_t  div_sel;

    opn_bus_latch u_bus_latch (
        .clk     (clk),
        .rst     (rst),
        .din     (din),
        .write   (write),
        .addr    (addr),
        .data_wr (data_wr),
        .sel_reg (sel_reg),
        .part    (part),
        .data    (data)
    );

    opn_global_regs #(
        .USE_PCM (USE_PCM)
    ) u_global_regs (
        .clk (clk), .rst (rst), .clk_en (clk_en), .data_wr (data_wr),
        .sel_reg (sel_reg), .data (data), .div_sel (div_sel),
        .eg_stop (eg_stop), .pg_stop (pg_stop), .fast_timers (fast_timers),
        .value_a (value_a), .value_b (value_b), .load_a (load_a), .load_b (load_b),
        .enable_irq_a (enable_irq_a), .enable_irq_b (enable_irq_b),
        .clr_flag_a (clr_flag_a), .clr_flag_b (clr_flag_b),
        .csm (csm), .effect (effect), .lfo_freq (lfo_freq), .lfo_en (lfo_en),
        .pcm (pcm), .pcm_en (pcm_en), .pcm_wr (pcm_wr)
    );

    opn_update_decode u_update_decode (
        .clk (clk), .rst (rst), .data_wr (data_wr), .part (part),
        .sel_reg (sel_reg), .data (data), .reg_data (reg_data),
        .up_keyon (up_keyon), .up_ch (up_ch), .up_op (up_op),
        .up_chreg (up_chreg), .up_opreg (up_opreg)
    );

    opn_prescaler u_prescaler (
        .clk (clk), .rst (rst), .cen (cen), .div_sel (div_sel), .clk_en (clk_en)
    );

    opn_busy_timer u_busy_timer (
        .clk (clk), .rst (rst), .clk_en (clk_en), .data_wr (data_wr), .busy (busy)
    );

endmodule

// File: verif/opn_mmr_tb.sv
`timescale 1ns/1ps

module opn_mmr_tb
    import opn_pkg::*;
();

    logic       clk;
    logic       rst;
    logic       cen;
    reg_data_t  din;
    logic       write;
    logic [1:0] addr;
    logic       clk_en, busy;
    logic       eg_stop, pg_stop, fast_timers;
    timer_a_t   value_a;
    timer_b_t   value_b;
    logic       load_a, load_b, enable_irq_a, enable_irq_b, clr_flag_a, clr_flag_b;
    logic       csm, effect, lfo_en, pcm_en, pcm_wr;
    logic [2:0] lfo_freq;
    pcm_t       pcm;
    reg_data_t  reg_data;
    logic       up_keyon;
    ch_sel_t    up_ch;
    op_sel_t    up_op;
    ch_upd_t    up_chreg;
    op_upd_t    up_opreg;

    logic       cen_random;   // Toggle cen while waiting for clk_en
    reg_addr_t  a;
    reg_data_t  d;
    logic       p;
    int         pulses;
    int         ratio;
    timer_a_t   exp_a;
    pcm_t       exp_pcm;

    opn_mmr #(.USE_PCM(1)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic expect_eq(input string what, input int got, input int want);
        assert (got == want) else begin
            $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, want);
            fail_run();
        end
    endtask

    task automatic timeout_error(input string what);
        $display("Timeout while waiting for %s", what);
        fail_run();
    endtask

    // Single-cycle strobes
    assert property (@(posedge clk) disable iff (rst) pcm_wr |=> !pcm_wr)
        else begin
            $display("[FAIL] %0t: pcm_wr high for more than one cycle", $time);
            fail_run();
        end
    assert property (@(posedge clk) disable iff (rst)
        (up_keyon || up_chreg != '0 || up_opreg != '0) |=>
        (!up_keyon && up_chreg == '0 && up_opreg == '0))
        else begin
            $display("[FAIL] %0t: update strobe high for more than one cycle", $time);
            fail_run();
        end

    task automatic write_addr(input reg_addr_t ra, input logic rp);
        @(negedge clk);
        addr  = {rp, 1'b0};
        din   = ra;
        write = 1'b1;
        @(negedge clk);
        write = 1'b0;
    endtask

    task automatic write_data(input reg_data_t rd);
        @(negedge clk);
        addr[0] = 1'b1;
        din     = rd;
        write   = 1'b1;
        @(negedge clk);
        write = 1'b0;
    endtask

    // Returns in the cycle where registers and strobes show the write
    task automatic write_reg(input reg_addr_t ra, input reg_data_t rd, input logic rp);
        write_addr(ra, rp);
        write_data(rd);
        @(negedge clk);
    endtask

    // Counts cen pulses up to and including the next clk_en
    task automatic next_clk_en(output int cen_pulses);
        int   cycles;
        logic hit;
        cycles     = 0;
        cen_pulses = 0;
        hit        = 1'b0;
        while (!hit) begin
            @(negedge clk);
            cycles++;
            if (cen) cen_pulses++;
            hit = clk_en;
            if (cen_random) cen = 1'($urandom_range(1, 0));
            if (cycles > 200) timeout_error("clk_en");
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy) begin
            @(negedge clk);
            cycles++;
            if (cycles > 1000) timeout_error("busy to clear");
        end
    endtask

    task automatic count_busy(input int n);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < n) begin
            @(negedge clk);
            cycles++;
            expect_eq("busy during count", int'(busy), 1);
            if (clk_en) seen++;
            if (cycles > 500) timeout_error("clk_en pulses while busy");
        end
    endtask

    function automatic op_upd_t op_strobe(input reg_addr_t ra);
        op_upd_t s;
        s = '0;
        if (ra[1:0] != 2'b11 && ra[7:4] >= 4'h3 && ra[7:4] <= 4'h9) begin
            s = op_upd_t'(7'h01 << (ra[7:4] - 4'h3));
        end
        return s;
    endfunction

    function automatic ch_upd_t ch_strobe(input reg_addr_t ra);
        ch_upd_t s;
        s = '0;
        if (ra[1:0] != 2'b11) begin
            if (ra[7:4] == 4'hA && ra[3:2] == 2'b00) s = 3'b001;
            else if (ra[7:4] == 4'hB && ra[3:2] == 2'b00) s = 3'b010;
            else if (ra[7:4] == 4'hB && ra[3:2] == 2'b01) s = 3'b100;
        end
        return s;
    endfunction

    initial begin
        void'($urandom(96));
        rst        = 1'b1;
        cen        = 1'b1;
        din        = '0;
        write      = 1'b0;
        addr       = '0;
        cen_random = 1'b0;
        exp_a      = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        expect_eq("busy after reset", int'(busy), 0);
        expect_eq("pcm_wr after reset", int'(pcm_wr), 0);
        expect_eq("up_chreg after reset", int'(up_chreg), 0);
        expect_eq("up_opreg after reset", int'(up_opreg), 0);
        expect_eq("up_keyon after reset", int'(up_keyon), 0);
        next_clk_en(pulses);
        next_clk_en(pulses);
        expect_eq("clk_en period after reset", pulses, 6);

        // Global registers
        repeat (3) begin
            d = 8'($urandom);
            write_reg(REG_TESTYM, d, 1'b0);
            expect_eq("eg_stop", int'(eg_stop), int'(d[5]));
            expect_eq("pg_stop", int'(pg_stop), int'(d[3]));
            expect_eq("fast_timers", int'(fast_timers), int'(d[2]));
            d = 8'($urandom);
            write_reg(REG_CLKA1, d, 1'b0);
            exp_a[9:2] = d;
            expect_eq("value_a high", int'(value_a), int'(exp_a));
            d = 8'($urandom);
            write_reg(REG_CLKA2, d, 1'b0);
            exp_a[1:0] = d[1:0];
            expect_eq("value_a low", int'(value_a), int'(exp_a));
            d = 8'($urandom);
            write_reg(REG_CLKB, d, 1'b0);
            expect_eq("value_b", int'(value_b), int'(d));
            d = 8'($urandom);
            write_reg(REG_TIMER, d, 1'b0);
            expect_eq("timer bits", int'({clr_flag_b, clr_flag_a, enable_irq_b,
                enable_irq_a, load_b, load_a}), int'(d[5:0]));
            expect_eq("effect", int'(effect), int'(d[7] | d[6]));
            expect_eq("csm", int'(csm), int'(d[7] & ~d[6]));
            next_clk_en(pulses);
            @(negedge clk);
            expect_eq("clear flags after clk_en", int'({clr_flag_b, clr_flag_a}), 0);
            d = 8'($urandom);
            write_reg(REG_LFO, d, 1'b0);
            expect_eq("lfo_en", int'(lfo_en), int'(d[3]));
            expect_eq("lfo_freq", int'(lfo_freq), int'(d[2:0]));
        end

        // PCM DAC
        d = 8'($urandom);
        write_reg(REG_PCM, d, 1'b0);
        exp_pcm = {~d[7], d[6:0], 1'b1};
        expect_eq("pcm", int'(pcm), int'(exp_pcm));
        expect_eq("pcm_wr in strobe cycle", int'(pcm_wr), 1);
        @(negedge clk);
        expect_eq("pcm_wr one cycle later", int'(pcm_wr), 0);
        d = 8'($urandom);
        write_reg(REG_DACTEST, d, 1'b0);
        exp_pcm[0] = d[3];
        expect_eq("pcm after DAC test", int'(pcm), int'(exp_pcm));
        d = 8'($urandom);
        write_reg(REG_PCM_EN, d, 1'b0);
        expect_eq("pcm_en", int'(pcm_en), int'(d[7]));

        // Update strobes towards the operator bank
        repeat (40) begin
            case ($urandom_range(3, 0))
                0: a = 8'($urandom_range(8'h9F, 8'h30));
                1: a = 8'($urandom_range(8'hA3, 8'hA0));
                2: a = 8'($urandom_range(8'hB7, 8'hB0));
                default: a = REG_KON;
            endcase
            p = 1'($urandom_range(1, 0));
            d = 8'($urandom);
            write_reg(a, d, p);
            expect_eq("up_opreg", int'(up_opreg), int'(op_strobe(a)));
            expect_eq("up_chreg", int'(up_chreg), int'(ch_strobe(a)));
            expect_eq("up_keyon", int'(up_keyon), int'(a == REG_KON));
            expect_eq("reg_data", int'(reg_data), int'(d));
            expect_eq("up_ch", int'(up_ch), int'({p, a[1:0]}));
            expect_eq("up_op", int'(up_op), int'(a[3:2]));
            @(negedge clk);
            expect_eq("strobes one cycle later",
                int'({up_keyon, up_chreg, up_opreg}), 0);
        end

        // Busy timer restarted once by a second write
        wait_idle();
        write_addr(REG_CLKB, 1'b0);
        write_data(8'($urandom));
        expect_eq("busy one cycle after write", int'(busy), 0);
        count_busy(10);
        write_data(8'($urandom));
        count_busy(BUSY_CYCLES);
        @(negedge clk);
        expect_eq("busy after last clk_en", int'(busy), 0);

        // Prescaler with a random cen
        cen_random = 1'b1;
        for (int i = 0; i < 3; i++) begin
            case (i)
                0: begin
                    a     = REG_CLK_N2;
                    ratio = 2;
                end
                1: begin
                    a     = REG_CLK_N3;
                    ratio = 3;
                end
                default: begin
                    a     = REG_CLK_N6;
                    ratio = 6;
                end
            endcase
            write_reg(a, 8'($urandom), 1'b0);
            next_clk_en(pulses);
            next_clk_en(pulses);
            repeat (5) begin
                next_clk_en(pulses);
                expect_eq("cen pulses per clk_en", pulses, ratio);
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: opn_mmr.f
rtl/opn_pkg.sv
rtl/opn_bus_latch.sv
rtl/opn_global_regs.sv
rtl/opn_update_decode.sv
rtl/opn_prescaler.sv
rtl/opn_busy_timer.sv
rtl/opn_mmr.sv
verif/opn_mmr_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := opn_mmr_tb
FILELIST  := opn_mmr.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   list the targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
